// File: tb.f
+incdir+rtl
rtl/serial_pkg.sv
rtl/serial_chan_if.sv
rtl/serial_apb_regs.sv
rtl/serial_clkgen.sv
rtl/serial_engine.sv
rtl/serial_rx_collect.sv
rtl/serial_top.sv
sim/serial_tb.sv

// File: Makefile
TOP := serial_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: sim/serial_tb.sv
`include "serial_cfg.svh"

module serial_tb import serial_pkg::*; ();

	localparam int CH = `SERIAL_CHANNELS;
	localparam int B = `SERIAL_BITS;
	localparam logic IDLE = 1'(`SERIAL_CLK_IDLE);
	// 13 words, each one transfer plus apb polling, then margin for reset and setup
	localparam int LIMIT = 13 * (B * 2 * `SERIAL_CLK_DIV + 60) + 400;

	logic clk;
	logic rst;
	logic [`SERIAL_ADDR_BITS-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [CH-1:0] ser_clk;
	logic [CH-1:0] ser_out;
	logic [CH-1:0] ser_in = '1;

	// device model state
	logic [CH-1:0] clk_last;
	logic [CH-1:0] cur_bit;
	// bits seen on ser_out, first one ends up in bit 0
	t_word seen [CH];

	// expected-value bookkeeping
	logic [31:0] lfsr;
	logic [CH-1:0] prev_bit;
	logic [CH-1:0] lsb_set;
	t_word sent [CH];
	logic [31:0] rd;
	int waits;
	string test_name;
	int errors = 0;
	int errs_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;

	serial_top serial_top_inst (
		.in_clk(clk), .in_rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .ser_clk(ser_clk), .ser_out(ser_out), .ser_in(ser_in)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// hard stop if a poll never sees done
	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// loopback device, echoes each bit one trailing edge later
	always @(negedge clk) begin
		for (int i = 0; i < CH; i++) begin
			if (rst) begin
				clk_last[i] = IDLE;
				cur_bit[i] = 1'b1;
				seen[i] = '1;
				// idle line counts as a previous bit of 1
				ser_in[i] = 1'b1 ^ logic'(i % 2);
			end else begin
				// data holds while the pulse is open
				if (ser_clk[i] != IDLE)
					cur_bit[i] = ser_out[i];
				if ((clk_last[i] != IDLE) && (ser_clk[i] == IDLE)) begin
					seen[i] = {cur_bit[i], seen[i][B-1:1]};
					// odd channels answer inverted
					ser_in[i] = cur_bit[i] ^ logic'(i % 2);
				end
				clk_last[i] = ser_clk[i];
			end
		end
	end

	// slave responds only inside an access phase
	a_ready_in_access: assert property (@(posedge clk) disable iff (rst)
		pready |-> (psel && penable))
		else begin
			$display("pready was raised outside an APB access phase");
			errors++;
		end

	a_err_with_ready: assert property (@(posedge clk) disable iff (rst)
		pslverr |-> pready)
		else begin
			$display("pslverr was raised without pready");
			errors++;
		end

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("Fail %s %s at 0x%h: expected %h, actual %h",
				test_name, what, paddr, exp, act);
			errors++;
		end
	endtask

	function automatic t_word reverse_bits(input t_word w);
		t_word r;
		for (int k = 0; k < B; k++)
			r[k] = w[B-1-k];
		return r;
	endfunction

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic t_word next_word();
		t_word w;
		for (int k = 0; k < B; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			w[k] = lfsr[0];
		end
		return w;
	endfunction

	// one apb transfer, result left in rd and waits
	task automatic apb_access(input logic wr, input int ch, input int off,
			input logic [31:0] wdata, input logic exp_err);
		@(negedge clk);
		paddr = `SERIAL_ADDR_BITS'(ch * 16 + off);
		pwrite = wr;
		pwdata = wdata;
		psel = 1'b1;
		@(negedge clk);
		penable = 1'b1;
		waits = 0;
		#1;
		while (!pready) begin
			waits++;
			@(negedge clk);
			#1;
		end
		rd = prdata;
		check_value("pslverr", 32'(exp_err), 32'(pslverr));
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic start_word(input int ch);
		sent[ch] = next_word();
		apb_access(1'b1, ch, reg_tx, 32'(sent[ch]), 1'b0);
	endtask

	// poll for done, then check order on the line, rx word and cleared status
	task automatic finish_word(input int ch);
		t_word order;
		t_word rx;
		order = lsb_set[ch] ? sent[ch] : reverse_bits(sent[ch]);
		// one bit late in transmit order, previous last bit comes first
		rx = {order[B-2:0], prev_bit[ch]} ^ {B{logic'(ch % 2)}};
		prev_bit[ch] = order[B-1];
		rd = '0;
		while (!rd[1])
			apb_access(1'b0, ch, reg_status, '0, 1'b0);
		check_value("ser_out order", 32'(order), 32'(seen[ch]));
		apb_access(1'b0, ch, reg_rx, '0, 1'b0);
		check_value("rx word", 32'(lsb_set[ch] ? rx : reverse_bits(rx)), rd);
		check_value("rx wait states", 1, 32'(waits));
		apb_access(1'b0, ch, reg_status, '0, 1'b0);
		check_value("status after read", 0, rd);
	endtask

	task automatic report_test();
		tests_run++;
		if (errors == errs_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d failed checks", test_name, errors - errs_at_start);
		end
		errs_at_start = errors;
	endtask

	initial begin
		int ch;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsr = 32'h3f6836df;
		prev_bit = '1;
		lsb_set = '1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_name = "reset";
		check_value("ser_clk", 32'({CH{IDLE}}), 32'(ser_clk));
		check_value("ser_out", 32'({CH{1'b1}}), 32'(ser_out));
		for (ch = 0; ch < CH; ch++) begin
			apb_access(1'b0, ch, reg_status, '0, 1'b0);
			check_value("status", 0, rd);
			apb_access(1'b0, ch, reg_ctrl, '0, 1'b0);
			check_value("lsb_first", 1, rd);
		end
		report_test();

		test_name = "lsb_first";
		for (ch = 0; ch < CH; ch++) begin
			start_word(ch);
			finish_word(ch);
		end
		report_test();

		test_name = "msb_first";
		for (ch = 0; ch < CH; ch++) begin
			apb_access(1'b1, ch, reg_ctrl, 32'd0, 1'b0);
			lsb_set[ch] = 1'b0;
			start_word(ch);
			finish_word(ch);
		end
		report_test();

		// channel 0 keeps shifting under the refused writes
		test_name = "refused";
		start_word(0);
		apb_access(1'b1, 0, reg_tx, 32'(next_word()), 1'b1);
		apb_access(1'b1, 0, reg_ctrl, 32'd1, 1'b1);
		finish_word(0);
		// offset 0x2 is no register
		apb_access(1'b1, 0, 2, 32'h5a, 1'b1);
		apb_access(1'b0, 0, 2, '0, 1'b1);
		check_value("unknown offset data", 0, rd);
		report_test();

		// even channels lsb first, odd msb first, all in flight together
		test_name = "concurrent";
		for (ch = 0; ch < CH; ch++) begin
			lsb_set[ch] = logic'((ch + 1) % 2);
			apb_access(1'b1, ch, reg_ctrl, 32'(lsb_set[ch]), 1'b0);
		end
		for (ch = 0; ch < CH; ch++)
			start_word(ch);
		for (ch = 0; ch < CH; ch++)
			finish_word(ch);
		report_test();

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: rtl/serial_top.sv
`include "serial_cfg.svh"

module serial_top import serial_pkg::*; (
	input logic in_clk,
	input logic in_rst,
	input logic [`SERIAL_ADDR_BITS-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [`SERIAL_CHANNELS-1:0] ser_clk,
	output logic [`SERIAL_CHANNELS-1:0] ser_out,
	input logic [`SERIAL_CHANNELS-1:0] ser_in
);

	// one link per channel
	serial_chan_if chan [`SERIAL_CHANNELS] ();

	// collector results back to the read mux
	t_word rd_data [`SERIAL_CHANNELS];
	logic [`SERIAL_CHANNELS-1:0] done;

	serial_apb_regs regs_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.chan(chan),
		.rd_data(rd_data),
		.done(done)
	);

	genvar i;
	generate
		for (i = 0; i < `SERIAL_CHANNELS; i++) begin : g_engine
			serial_engine engine_inst (
				.in_clk(in_clk),
				.in_rst(in_rst),
				.chan(chan[i]),
				.ser_clk(ser_clk[i]),
				.ser_out(ser_out[i]),
				.ser_in(ser_in[i])
			);
		end
	endgenerate

	serial_rx_collect collect_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.chan(chan),
		.rd_data(rd_data),
		.done(done)
	);

endmodule

// File: rtl/serial_rx_collect.sv
`include "serial_cfg.svh"

module serial_rx_collect import serial_pkg::*; (
	input logic in_clk,
	input logic in_rst,
	serial_chan_if.collect chan [`SERIAL_CHANNELS],
	output t_word rd_data [`SERIAL_CHANNELS],
	output logic [`SERIAL_CHANNELS-1:0] done
);

	genvar i;
	generate
		for (i = 0; i < `SERIAL_CHANNELS; i++) begin : g_chan
			// last word from this engine
			t_word word_q;
			// sticky until the host reads reg_rx
			logic done_q;

			// newer word overwrites an unread one
			always_ff @(posedge in_clk) begin
				if (chan[i].rx_valid)
					word_q <= chan[i].rx_word;
			end

			always_ff @(posedge in_clk) begin
				if (in_rst) begin
					done_q <= 1'b0;
				end else if (chan[i].rx_valid) begin
					// set wins over a clearing read
					done_q <= 1'b1;
				end else if (chan[i].rd_ack) begin
					done_q <= 1'b0;
				end
			end

			assign rd_data[i] = word_q;
			assign done[i] = done_q;

			// register block acks only a pending word
			a_ack_pending: assert property (
				@(posedge in_clk) disable iff (in_rst)
				chan[i].rd_ack |-> done_q
			);
		end
	endgenerate

endmodule

// File: rtl/serial_engine.sv
`include "serial_cfg.svh"

module serial_engine import serial_pkg::*; (
	input logic in_clk,
	input logic in_rst,
	serial_chan_if.engine chan,
	output logic ser_clk,
	output logic ser_out,
	input logic ser_in
);

	localparam int CTR_BITS = ($clog2(`SERIAL_BITS) > 0) ? $clog2(`SERIAL_BITS) : 1;
	localparam logic [CTR_BITS-1:0] LAST_BIT = CTR_BITS'(`SERIAL_BITS - 1);
	// in_clk cycles spent in transmit for one word
	localparam int WORD_CYCLES = 2 * `SERIAL_CLK_DIV * `SERIAL_BITS;

	t_serial_state state;

	// bit counter in transmit order
	logic [CTR_BITS-1:0] bit_ctr;
	// same counter mapped to a word position
	logic [CTR_BITS-1:0] bit_pos;

	// words latched at start and built during shifting
	t_word tx_q;
	t_word rx_q;
	logic lsb_q;

	logic ser_out_q;
	logic rx_valid_q;

	// divider handshake
	logic run;
	logic tick_lead;
	logic tick_trail;

	assign run = (state == transmit);

	serial_clkgen clkgen_inst (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.run(run),
		.sclk(ser_clk),
		.tick_lead(tick_lead),
		.tick_trail(tick_trail)
	);

	// lsb first walks up, msb first walks down
	assign bit_pos = lsb_q ? bit_ctr : (LAST_BIT - bit_ctr);

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= ready;
			bit_ctr <= '0;
			ser_out_q <= 1'b1;
			rx_valid_q <= 1'b0;
		end else begin
			rx_valid_q <= 1'b0;
			case (state)
				// wait for a start pulse
				ready: begin
					bit_ctr <= '0;
					ser_out_q <= 1'b1;
					if (chan.start)
						state <= transmit;
				end

				transmit: begin
					// drive next bit as the pulse opens
					if (tick_lead)
						ser_out_q <= tx_q[bit_pos];

					// pulse closes, advance or finish
					if (tick_trail) begin
						if (bit_ctr == LAST_BIT) begin
							state <= ready;
							bit_ctr <= '0;
							ser_out_q <= 1'b1;
							rx_valid_q <= 1'b1;
						end else begin
							bit_ctr <= bit_ctr + 1'b1;
						end
					end
				end

				default: state <= ready;
			endcase
		end
	end

	always_ff @(posedge in_clk) begin
		// settings frozen for the whole word
		if ((state == ready) && chan.start) begin
			tx_q <= chan.tx_word;
			lsb_q <= chan.lsb_first;
		end
		// sample device line where the pulse closes
		if ((state == transmit) && tick_trail)
			rx_q[bit_pos] <= ser_in;
	end

	assign chan.busy = run;
	assign chan.rx_word = rx_q;
	assign chan.rx_valid = rx_valid_q;
	assign ser_out = ser_out_q;

	// register block must not start a busy channel
	a_start_ready: assert property (
		@(posedge in_clk) disable iff (in_rst)
		chan.start |-> (state == ready)
	);

	// finished word closes a transmit run of full word length
	a_valid_after_tx: assert property (
		@(posedge in_clk) disable iff (in_rst)
		chan.rx_valid |-> ($past(state) == transmit) && $past(run, WORD_CYCLES)
			&& !$past(run, WORD_CYCLES + 1)
	);

endmodule

// File: rtl/serial_clkgen.sv
`include "serial_cfg.svh"

module serial_clkgen (
	input logic in_clk,
	input logic in_rst,
	input logic run,
	output logic sclk,
	output logic tick_lead,
	output logic tick_trail
);

	// wide enough for a divider of 1
	localparam int CNT_BITS = $clog2(`SERIAL_CLK_DIV + 1);

	logic [CNT_BITS-1:0] cnt;
	logic half_end;

	// last cycle of a half period
	assign half_end = run && (cnt == CNT_BITS'(`SERIAL_CLK_DIV - 1));

	// leaving idle level starts the pulse
	assign tick_lead = half_end && (sclk == 1'(`SERIAL_CLK_IDLE));
	// returning to idle level ends it
	assign tick_trail = half_end && (sclk != 1'(`SERIAL_CLK_IDLE));

	always_ff @(posedge in_clk) begin
		if (in_rst || !run) begin
			// parked at idle between transfers
			cnt <= '0;
			sclk <= 1'(`SERIAL_CLK_IDLE);
		end else if (half_end) begin
			cnt <= '0;
			sclk <= ~sclk;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: rtl/serial_apb_regs.sv
`include "serial_cfg.svh"

module serial_apb_regs import serial_pkg::*; (
	input logic in_clk,
	input logic in_rst,
	input logic [`SERIAL_ADDR_BITS-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	serial_chan_if.regs chan [`SERIAL_CHANNELS],
	input t_word rd_data [`SERIAL_CHANNELS],
	input logic [`SERIAL_CHANNELS-1:0] done
);

	// per-channel host registers
	t_word tx_word_q [`SERIAL_CHANNELS];
	logic [`SERIAL_CHANNELS-1:0] lsb_first_q;
	logic [`SERIAL_CHANNELS-1:0] start_q;
	logic [`SERIAL_CHANNELS-1:0] rd_ack_q;
	logic [`SERIAL_CHANNELS-1:0] busy;

	// rx read takes one wait state
	logic rx_wait;
	t_word rx_q;

	// address decode
	t_chan ch;
	t_reg off;
	logic chan_ok;
	logic off_ok;
	logic addr_ok;

	// access qualifiers
	logic access;
	logic rx_read;
	logic rx_first;
	logic busy_sel;
	logic wr_refused;
	logic wr_tx;
	logic wr_ctrl;

	// channel in the upper nibble
	assign ch = t_chan'(paddr >> 4);
	assign off = t_reg'(paddr[3:0]);
	assign chan_ok = (paddr >> 4) < `SERIAL_CHANNELS;

	always_comb begin
		case (off)
			reg_tx, reg_status, reg_rx, reg_ctrl: off_ok = 1'b1;
			default: off_ok = 1'b0;
		endcase
	end

	assign addr_ok = chan_ok && off_ok;
	assign access = psel && penable;

	// a start still in flight counts as busy
	assign busy_sel = busy[ch] || start_q[ch];

	assign rx_read = addr_ok && !pwrite && (off == reg_rx);
	// first access cycle of an rx read
	assign rx_first = access && rx_read && !rx_wait;

	// everything but rx reads ends in the first access cycle
	assign pready = access && (!rx_read || rx_wait);

	// tx and ctrl are locked while the channel shifts
	assign wr_refused = pwrite && ((off == reg_tx) || (off == reg_ctrl)) && busy_sel;
	assign pslverr = pready && (!addr_ok || wr_refused);

	assign wr_tx = pready && addr_ok && pwrite && (off == reg_tx) && !busy_sel;
	assign wr_ctrl = pready && addr_ok && pwrite && (off == reg_ctrl) && !busy_sel;

	// read mux, zero for unknown addresses and writes
	always_comb begin
		prdata = '0;
		if (access && addr_ok && !pwrite) begin
			case (off)
				reg_tx: prdata = 32'(tx_word_q[ch]);
				reg_status: prdata = {30'd0, done[ch], busy_sel};
				reg_rx: prdata = 32'(rx_q);
				reg_ctrl: prdata = {31'd0, lsb_first_q[ch]};
				default: prdata = '0;
			endcase
		end
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			start_q <= '0;
			rd_ack_q <= '0;
			rx_wait <= 1'b0;
			lsb_first_q <= '1;
		end else begin
			// single-cycle pulses
			start_q <= '0;
			rd_ack_q <= '0;
			rx_wait <= rx_first;
			if (wr_tx)
				start_q[ch] <= 1'b1;
			if (wr_ctrl)
				lsb_first_q[ch] <= pwdata[0];
			// ack lands in the completing cycle, only if there is a word
			if (rx_first)
				rd_ack_q[ch] <= done[ch];
		end
	end

	always_ff @(posedge in_clk) begin
		if (wr_tx)
			tx_word_q[ch] <= pwdata[`SERIAL_BITS-1:0];
		// hold collector word for the wait state
		if (rx_first)
			rx_q <= rd_data[ch];
	end

	genvar i;
	generate
		for (i = 0; i < `SERIAL_CHANNELS; i++) begin : g_chan
			assign chan[i].start = start_q[i];
			assign chan[i].tx_word = tx_word_q[i];
			assign chan[i].lsb_first = lsb_first_q[i];
			assign chan[i].rd_ack = rd_ack_q[i];
			assign busy[i] = chan[i].busy;
		end
	endgenerate

	// master keeps address and direction from setup into access
	a_setup_stable: assert property (
		@(posedge in_clk) disable iff (in_rst)
		(psel && !penable) |=> ($stable(paddr) && $stable(pwrite))
	);

endmodule

// File: rtl/serial_chan_if.sv
interface serial_chan_if import serial_pkg::*; ();

	// transfer request from the register block
	logic start;
	t_word tx_word;
	logic lsb_first;

	// engine status and finished word
	logic busy;
	t_word rx_word;
	logic rx_valid;

	// host has read the rx register
	logic rd_ack;

	// register block side
	modport regs (
		output start, output tx_word, output lsb_first, output rd_ack,
		input busy
	);

	// shift engine side
	modport engine (
		input start, input tx_word, input lsb_first,
		output busy, output rx_word, output rx_valid
	);

	// collector only listens
	modport collect (input rx_word, input rx_valid, input rd_ack);

endinterface

// File: rtl/serial_pkg.sv
`include "serial_cfg.svh"

package serial_pkg;

	// at least one bit even for a single channel
	localparam int CHAN_BITS = (`SERIAL_CHANNELS > 1) ? $clog2(`SERIAL_CHANNELS) : 1;

	// one serial word
	typedef logic [`SERIAL_BITS-1:0] t_word;

	// channel index
	typedef logic [CHAN_BITS-1:0] t_chan;

	// register offsets inside one channel window
	typedef enum logic [3:0] {
		// write starts a transfer
		reg_tx     = 4'h0,
		// bit 0 busy, bit 1 done
		reg_status = 4'h4,
		// received word, read clears done
		reg_rx     = 4'h8,
		// bit 0 lsb_first
		reg_ctrl   = 4'hC
	} t_reg;

	// engine states
	typedef enum logic {
		ready,
		transmit
	} t_serial_state;

endpackage

// File: rtl/serial_cfg.svh
`ifndef SERIAL_CFG_SVH
`define SERIAL_CFG_SVH

// number of channel engines
`define SERIAL_CHANNELS 4

// bits per serial word
`define SERIAL_BITS 8

// in_clk cycles per half period of the serial clock
`define SERIAL_CLK_DIV 4

// serial clock level between transfers
`define SERIAL_CLK_IDLE 1

// apb address width
// upper nibble picks the channel, lower nibble the register
`define SERIAL_ADDR_BITS 8

`endif
